// ==== ctrl_pkg.sv ====
// State encoding of the execution control FSM
// Used by the FSM itself and by the bound control checks
`default_nettype none

package ctrl_pkg;

  // --------------------
  // Control states
  // --------------------

  typedef enum logic [2:0] {
    // Waiting for a start pulse
    ST_IDLE  = 3'd0,
    // Sources read, ALU result and multiplier operands captured
    ST_READ  = 3'd1,
    // One shift-add step per cycle
    ST_MUL   = 3'd2,
    // Writeback cycle, done pulses here
    ST_WRITE = 3'd3
  } state_e;

endpackage

`default_nettype wire

// ==== exec_alu.sv ====
// Single-cycle ALU with a registered result
// Evaluates the opcode when load is high and holds the result otherwise
`timescale 1ns/1ps
`default_nettype none

module exec_alu #(
  parameter int p_data_nbits = 32
) (
  input  logic                    clk,
  input  logic                    load,
  input  isa_pkg::opcode_e        op,
  input  logic [p_data_nbits-1:0] a,
  input  logic [p_data_nbits-1:0] b,
  input  logic [p_data_nbits-1:0] imm,
  output logic [p_data_nbits-1:0] alu_result
);

  // Shift amount width, log2 of the data width
  localparam int c_shamt_nbits = $clog2(p_data_nbits);

  logic [c_shamt_nbits-1:0] shamt;
  logic [p_data_nbits-1:0]  alu_next;

  // Only the low bits of operand b steer the shifter
  assign shamt = b[c_shamt_nbits-1:0];

  // --------------------
  // Operation select
  // --------------------

  always_comb begin
    case (op)
      isa_pkg::OP_LDI: alu_next = imm;
      isa_pkg::OP_ADD: alu_next = a + b;
      isa_pkg::OP_SUB: alu_next = a - b;
      isa_pkg::OP_AND: alu_next = a & b;
      isa_pkg::OP_OR:  alu_next = a | b;
      isa_pkg::OP_XOR: alu_next = a ^ b;
      isa_pkg::OP_SLL: alu_next = a << shamt;
      isa_pkg::OP_SRL: alu_next = a >> shamt;
      // Multiply goes through the shift-add unit, keep the old value
      default:         alu_next = alu_result;
    endcase
  end

  // --------------------
  // Result register
  // --------------------

  // Payload only, no reset
  always_ff @(posedge clk) begin
    if (load) begin
      alu_result <= alu_next;
    end
  end

endmodule

`default_nettype wire

// ==== exec_core_properties.sv ====
// Concurrent checks on the control FSM outputs
// Bound into every exec_ctrl_fsm instance
`timescale 1ns/1ps
`default_nettype none

module exec_core_properties #(
  parameter int p_data_nbits = 32
) (
  input logic                              clk,
  input logic                              reset,
  input logic                              start,
  input logic                              busy,
  input logic                              done,
  input logic                              rf_write_en,
  input logic                              mul_step,
  input logic [isa_pkg::reg_idx_nbits-1:0] rd_q,
  input isa_pkg::opcode_e                  op_q,
  input ctrl_pkg::state_e                  state
);

  // Length of the current run of multiply steps
  int mul_cycles;

  always_ff @(posedge clk) begin
    if (reset || !mul_step) begin
      mul_cycles <= 0;
    end else begin
      mul_cycles <= mul_cycles + 1;
    end
  end

  // --------------------
  // Handshake checks
  // --------------------

  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  done_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
    else $error("done high while busy is low");

  write_is_done: assert property (@(posedge clk) disable iff (reset) rf_write_en == done)
    else $error("register write enable differs from done");

  // A start seen while busy leaves the latched command alone
  start_ignored: assert property (@(posedge clk) disable iff (reset)
                                  (start && busy) |=> ($stable(rd_q) && $stable(op_q)))
    else $error("start while busy changed the latched command");

  reset_quiet: assert property (@(posedge clk)
                                reset |=> (state == ctrl_pkg::ST_IDLE && !busy && !done))
    else $error("FSM not idle, or busy or done high, right after reset");

  mul_length: assert property (@(posedge clk) disable iff (reset)
                               mul_step |-> (mul_cycles < p_data_nbits))
    else $error("multiply ran past the data width in steps");

endmodule

// Data width matches the testbench's DUT
bind exec_ctrl_fsm exec_core_properties #(.p_data_nbits(32)) ctrl_props (
  .clk        (clk),
  .reset      (reset),
  .start      (start),
  .busy       (busy),
  .done       (done),
  .rf_write_en(rf_write_en),
  .mul_step   (mul_step),
  .rd_q       (rd_q),
  .op_q       (op_q),
  .state      (state)
);

`default_nettype wire

// ==== exec_core_top.sv ====
// Top level of the multicycle execution unit
// Wires control, step counter, register file, ALU and multiplier together
`timescale 1ns/1ps
`default_nettype none

module exec_core_top #(
  parameter int p_data_nbits = 32
) (
  input  logic                              clk,
  input  logic                              reset,

  // Command, fields sampled with start while idle
  input  logic                              start,
  input  isa_pkg::opcode_e                  opcode,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rd,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rs1,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rs2,
  // Sampled by the ALU in the cycle after start, hold it stable until then
  input  logic [p_data_nbits-1:0]           imm,

  // Status and writeback value
  output logic                              busy,
  output logic                              done,
  output logic [p_data_nbits-1:0]           result
);

  // --------------------
  // Internal wires
  // --------------------

  logic [isa_pkg::reg_idx_nbits-1:0] rd_q;
  logic [isa_pkg::reg_idx_nbits-1:0] rs1_q;
  logic [isa_pkg::reg_idx_nbits-1:0] rs2_q;
  isa_pkg::opcode_e                  op_q;

  logic alu_load;
  logic mul_load;
  logic cnt_load;
  logic cnt_en;
  logic cnt_last;
  logic mul_step;
  logic use_mul;
  logic rf_write_en;

  logic [p_data_nbits-1:0] src1_data;
  logic [p_data_nbits-1:0] src2_data;
  logic [p_data_nbits-1:0] alu_result;
  logic [p_data_nbits-1:0] product;
  logic [p_data_nbits-1:0] wb_data;

  // --------------------
  // Control
  // --------------------

  exec_ctrl_fsm ctrl (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .opcode     (opcode),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .cnt_last   (cnt_last),
    .rd_q       (rd_q),
    .rs1_q      (rs1_q),
    .rs2_q      (rs2_q),
    .op_q       (op_q),
    .alu_load   (alu_load),
    .mul_load   (mul_load),
    .cnt_load   (cnt_load),
    .cnt_en     (cnt_en),
    .mul_step   (mul_step),
    .use_mul    (use_mul),
    .rf_write_en(rf_write_en),
    .busy       (busy),
    .done       (done)
  );

  step_counter #(.p_data_nbits(p_data_nbits)) step_cnt (
    .clk  (clk),
    .reset(reset),
    .load (cnt_load),
    .en   (cnt_en),
    .last (cnt_last)
  );

  // --------------------
  // Datapath
  // --------------------

  regfile_2r1w_zero #(.p_data_nbits(p_data_nbits)) rf (
    .clk       (clk),
    .read_addr0(rs1_q),
    .read_data0(src1_data),
    .read_addr1(rs2_q),
    .read_data1(src2_data),
    .write_en  (rf_write_en),
    .write_addr(rd_q),
    .write_data(wb_data)
  );

  exec_alu #(.p_data_nbits(p_data_nbits)) alu (
    .clk       (clk),
    .load      (alu_load),
    .op        (op_q),
    .a         (src1_data),
    .b         (src2_data),
    .imm       (imm),
    .alu_result(alu_result)
  );

  shift_add_mul #(.p_data_nbits(p_data_nbits)) mul (
    .clk    (clk),
    .load   (mul_load),
    .step   (mul_step),
    .a      (src1_data),
    .b      (src2_data),
    .product(product)
  );

  // Writeback source, also shown on result
  assign wb_data = use_mul ? product : alu_result;
  assign result  = wb_data;

endmodule

`default_nettype wire

// ==== exec_ctrl_fsm.sv ====
// Control FSM of the execution unit
// Latches a command on start and sequences read, execute and writeback
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl_fsm (
  input  logic                              clk,
  input  logic                              reset,

  // Command from the outside agent
  input  logic                              start,
  input  isa_pkg::opcode_e                  opcode,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rd,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rs1,
  input  logic [isa_pkg::reg_idx_nbits-1:0] rs2,

  // Step counter status
  input  logic                              cnt_last,

  // Latched command
  output logic [isa_pkg::reg_idx_nbits-1:0] rd_q,
  output logic [isa_pkg::reg_idx_nbits-1:0] rs1_q,
  output logic [isa_pkg::reg_idx_nbits-1:0] rs2_q,
  output isa_pkg::opcode_e                  op_q,

  // Datapath controls
  output logic                              alu_load,
  output logic                              mul_load,
  output logic                              cnt_load,
  output logic                              cnt_en,
  output logic                              mul_step,
  output logic                              use_mul,
  output logic                              rf_write_en,

  // Status to the outside agent
  output logic                              busy,
  output logic                              done
);

  ctrl_pkg::state_e state;
  ctrl_pkg::state_e state_next;

  logic accept;

  // Start only counts while idle
  assign accept = (state == ctrl_pkg::ST_IDLE) && start;

  // --------------------
  // Command latch
  // --------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= opcode;
      rd_q  <= rd;
      rs1_q <= rs1;
      rs2_q <= rs2;
    end
  end

  // --------------------
  // State register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrl_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ctrl_pkg::ST_IDLE:  if (accept) state_next = ctrl_pkg::ST_READ;
      // Multiply takes the long path
      ctrl_pkg::ST_READ:  state_next = use_mul ? ctrl_pkg::ST_MUL : ctrl_pkg::ST_WRITE;
      ctrl_pkg::ST_MUL:   if (cnt_last) state_next = ctrl_pkg::ST_WRITE;
      ctrl_pkg::ST_WRITE: state_next = ctrl_pkg::ST_IDLE;
      default:            state_next = ctrl_pkg::ST_IDLE;
    endcase
  end

  // --------------------
  // Outputs
  // --------------------

  assign use_mul = (op_q == isa_pkg::OP_MUL);

  // Operands are captured at the end of the read cycle
  assign alu_load = (state == ctrl_pkg::ST_READ);
  assign mul_load = (state == ctrl_pkg::ST_READ) && use_mul;
  assign cnt_load = (state == ctrl_pkg::ST_READ) && use_mul;

  // One multiply step per ST_MUL cycle
  assign mul_step = (state == ctrl_pkg::ST_MUL);
  assign cnt_en   = (state == ctrl_pkg::ST_MUL);

  assign rf_write_en = (state == ctrl_pkg::ST_WRITE);
  assign done        = (state == ctrl_pkg::ST_WRITE);
  assign busy        = (state != ctrl_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== files.f ====
isa_pkg.sv
ctrl_pkg.sv
regfile_2r1w_zero.sv
exec_alu.sv
shift_add_mul.sv
step_counter.sv
exec_ctrl_fsm.sv
exec_core_top.sv
exec_core_properties.sv
tb_exec_core.sv

// ==== isa_pkg.sv ====
// Command encoding shared by the execution unit and its testbench
// Holds the opcode set and the register index sizing
`default_nettype none

package isa_pkg;

  // --------------------
  // Register file sizing
  // --------------------

  // Width of every register index (rd, rs1, rs2)
  localparam int reg_idx_nbits = 5;

  // Number of architectural registers, r0 always reads as zero
  localparam int num_regs = 32;

  // --------------------
  // Opcodes
  // --------------------

  typedef enum logic [3:0] {
    // Write the immediate
    OP_LDI = 4'd0,
    // Arithmetic on rs1 and rs2
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    // Bitwise logic
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    // Shift rs1 by the low log2(width) bits of rs2
    OP_SLL = 4'd6,
    OP_SRL = 4'd7,
    // Low word of rs1 * rs2, multicycle
    OP_MUL = 4'd8
  } opcode_e;

endpackage

`default_nettype wire

// ==== regfile_2r1w_zero.sv ====
// Two-read one-write register file with r0 hardwired to zero
// Reads are combinational, the single write lands on the rising edge
`timescale 1ns/1ps
`default_nettype none

module regfile_2r1w_zero #(
  parameter int p_data_nbits = 32
) (
  input  logic                            clk,

  // Read port 0
  input  logic [isa_pkg::reg_idx_nbits-1:0] read_addr0,
  output logic [p_data_nbits-1:0]           read_data0,

  // Read port 1
  input  logic [isa_pkg::reg_idx_nbits-1:0] read_addr1,
  output logic [p_data_nbits-1:0]           read_data1,

  // Write port, sampled on the rising edge
  input  logic                              write_en,
  input  logic [isa_pkg::reg_idx_nbits-1:0] write_addr,
  input  logic [p_data_nbits-1:0]           write_data
);

  // Storage array, no reset on the contents
  logic [p_data_nbits-1:0] rfile [isa_pkg::num_regs];

  // --------------------
  // Write port
  // --------------------

  // A write to r0 still lands in the array but is never visible
  always_ff @(posedge clk) begin
    if (write_en) begin
      rfile[write_addr] <= write_data;
    end
  end

  // --------------------
  // Read ports
  // --------------------

  // Index 0 is masked to zero on both ports
  assign read_data0 = (read_addr0 == '0) ? '0 : rfile[read_addr0];
  assign read_data1 = (read_addr1 == '0) ? '0 : rfile[read_addr1];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_exec_core -o sim_exec_core > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_exec_core > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== shift_add_mul.sv ====
// Iterative shift-add multiplier, one multiplier bit per step
// Load the operands, apply p_data_nbits steps, then read the low word
`timescale 1ns/1ps
`default_nettype none

module shift_add_mul #(
  parameter int p_data_nbits = 32
) (
  input  logic                    clk,
  input  logic                    load,
  input  logic                    step,
  input  logic [p_data_nbits-1:0] a,
  input  logic [p_data_nbits-1:0] b,
  output logic [p_data_nbits-1:0] product
);

  // Multiplicand shifts left each step
  logic [p_data_nbits-1:0] mcand;

  // Multiplier shifts right, bit 0 is the current bit
  logic [p_data_nbits-1:0] mplier;

  // Running sum, only the low word is kept
  logic [p_data_nbits-1:0] acc;

  // --------------------
  // Datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
    end else if (step) begin
      // Add the shifted multiplicand when the current bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Bits above the word drop out of mcand and acc, giving the low word
  assign product = acc;

endmodule

`default_nettype wire

// ==== step_counter.sv ====
// Down counter that paces the multiply steps
// Load sets it to the data width, last flags the final step
`timescale 1ns/1ps
`default_nettype none

module step_counter #(
  parameter int p_data_nbits = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic en,
  output logic last
);

  // Wide enough to hold p_data_nbits itself
  localparam int c_count_nbits = $clog2(p_data_nbits + 1);
  localparam logic [c_count_nbits-1:0] c_count_init = c_count_nbits'(p_data_nbits);

  logic [c_count_nbits-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= c_count_init;
    end else if (en && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  // High during the last enabled cycle
  assign last = (count == c_count_nbits'(1));

endmodule

`default_nettype wire

// ==== tb_exec_core.sv ====
// Random-command testbench for the multicycle execution unit
// Drives one command at a time and checks results and timing against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

  localparam int c_data_nbits     = 32;
  localparam int c_shamt_nbits    = $clog2(c_data_nbits);
  // Cycles from the start edge to the done cycle
  localparam int c_alu_latency    = 2;
  localparam int c_mul_latency    = c_data_nbits + 2;
  localparam int c_timeout_cycles = 64;
  localparam int c_num_random     = 300;

  logic                              clk;
  logic                              reset;
  logic                              start;
  isa_pkg::opcode_e                  opcode;
  logic [isa_pkg::reg_idx_nbits-1:0] rd;
  logic [isa_pkg::reg_idx_nbits-1:0] rs1;
  logic [isa_pkg::reg_idx_nbits-1:0] rs2;
  logic [c_data_nbits-1:0]           imm;
  logic                              busy;
  logic                              done;
  logic [c_data_nbits-1:0]           result;

  // Register model, entry 0 stays zero
  logic [c_data_nbits-1:0] model_regs [isa_pkg::num_regs];

  // Value seen on result in the done cycle of the last command
  logic [c_data_nbits-1:0] observed_result;

  integer seed;
  int     value_errors;
  int     timeout_errors;
  bit     stop_run;

  exec_core_top #(.p_data_nbits(c_data_nbits)) uut (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .opcode(opcode),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2),
    .imm   (imm),
    .busy  (busy),
    .done  (done),
    .result(result)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // --------------------
  // Reference model
  // --------------------

  function automatic logic [c_data_nbits-1:0] expected_value(
    input isa_pkg::opcode_e        op,
    input logic [c_data_nbits-1:0] a,
    input logic [c_data_nbits-1:0] b,
    input logic [c_data_nbits-1:0] value
  );
    logic [c_shamt_nbits-1:0]  shamt;
    logic [2*c_data_nbits-1:0] full;
    shamt = b[c_shamt_nbits-1:0];
    // Full product, the low word is what gets written
    full  = {{c_data_nbits{1'b0}}, a} * {{c_data_nbits{1'b0}}, b};
    case (op)
      isa_pkg::OP_LDI: expected_value = value;
      isa_pkg::OP_ADD: expected_value = a + b;
      isa_pkg::OP_SUB: expected_value = a - b;
      isa_pkg::OP_AND: expected_value = a & b;
      isa_pkg::OP_OR:  expected_value = a | b;
      isa_pkg::OP_XOR: expected_value = a ^ b;
      isa_pkg::OP_SLL: expected_value = a << shamt;
      isa_pkg::OP_SRL: expected_value = a >> shamt;
      isa_pkg::OP_MUL: expected_value = full[c_data_nbits-1:0];
      default:         expected_value = '0;
    endcase
  endfunction

  // --------------------
  // Compare tasks
  // --------------------

  task automatic compare_word(input string name, input logic [c_data_nbits-1:0] expected,
                              input logic [c_data_nbits-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL time %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      value_errors++;
      $display("FAIL time %0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  // --------------------
  // Command driver
  // --------------------

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < c_timeout_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy) begin
      $display("Timeout: unit still busy after %0d cycles, no new command issued",
               c_timeout_cycles);
      timeout_errors++;
      stop_run = 1'b1;
    end
  endtask

  // Issue one command, optionally poke start again while it runs
  task automatic run_command(input isa_pkg::opcode_e op,
                             input logic [isa_pkg::reg_idx_nbits-1:0] dst,
                             input logic [isa_pkg::reg_idx_nbits-1:0] src1,
                             input logic [isa_pkg::reg_idx_nbits-1:0] src2,
                             input logic [c_data_nbits-1:0] value,
                             input bit poke_busy);
    logic [c_data_nbits-1:0] expected;
    int                      cycles;
    bit                      seen_done;
    if (stop_run) return;
    wait_idle();
    if (stop_run) return;
    expected = expected_value(op, model_regs[src1], model_regs[src2], value);
    opcode   = op;
    rd       = dst;
    rs1      = src1;
    rs2      = src2;
    imm      = value;
    start    = 1'b1;
    // Start edge
    @(posedge clk);
    #1;
    start     = 1'b0;
    // Now in the first cycle after the start edge
    cycles    = 1;
    seen_done = 1'b0;
    while (!seen_done && cycles < c_timeout_cycles) begin
      if (poke_busy && cycles == 1) begin
        // Sampled during ST_READ, must be dropped, imm stays put
        opcode = isa_pkg::OP_LDI;
        rd     = ~dst;
        start  = 1'b1;
      end
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles++;
      compare_bit("busy", 1'b1, busy);
      seen_done = done;
    end
    if (!seen_done) begin
      $display("Timeout: no done within %0d cycles for opcode %s", c_timeout_cycles, op.name());
      timeout_errors++;
      stop_run = 1'b1;
      return;
    end
    compare_count("done latency", (op == isa_pkg::OP_MUL) ? c_mul_latency : c_alu_latency,
                  cycles);
    compare_word("result", expected, result);
    observed_result = result;
    if (dst != '0) begin
      model_regs[dst] = expected;
    end
    // Unit back to idle, no second done pulse
    @(posedge clk);
    #1;
    compare_bit("done", 1'b0, done);
    compare_bit("busy", 1'b0, busy);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    logic [31:0]      rnd;
    logic [31:0]      op_sel;
    logic [31:0]      value;
    isa_pkg::opcode_e op;
    seed            = 32'hfbe2;
    clk             = 1'b0;
    reset           = 1'b1;
    start           = 1'b0;
    opcode          = isa_pkg::OP_LDI;
    rd              = '0;
    rs1             = '0;
    rs2             = '0;
    imm             = '0;
    value_errors    = 0;
    timeout_errors  = 0;
    stop_run        = 1'b0;
    observed_result = '0;
    for (int i = 0; i < isa_pkg::num_regs; i++) begin
      model_regs[i] = '0;
    end

    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    compare_bit("busy", 1'b0, busy);
    compare_bit("done", 1'b0, done);

    // Known contents in r1..r31
    for (int i = 1; i < isa_pkg::num_regs; i++) begin
      value = $random(seed);
      run_command(isa_pkg::OP_LDI, i[4:0], '0, '0, value, 1'b0);
    end

    // Load then double through the same source register
    value = $random(seed);
    run_command(isa_pkg::OP_LDI, 5'd5, '0, '0, value, 1'b0);
    run_command(isa_pkg::OP_ADD, 5'd6, 5'd5, 5'd5, '0, 1'b0);
    compare_word("r6 doubled", value + value, observed_result);
    run_command(isa_pkg::OP_XOR, 5'd7, 5'd6, 5'd1, '0, 1'b0);

    // r0 drops writes and reads back as zero
    run_command(isa_pkg::OP_LDI, 5'd0, '0, '0, 32'hdead_beef, 1'b0);
    run_command(isa_pkg::OP_OR, 5'd8, 5'd0, 5'd0, '0, 1'b0);

    // Start while busy, once per path
    run_command(isa_pkg::OP_SUB, 5'd9, 5'd3, 5'd4, '0, 1'b1);
    run_command(isa_pkg::OP_MUL, 5'd10, 5'd9, 5'd2, '0, 1'b1);

    // Random commands over all opcodes
    for (int n = 0; n < c_num_random; n++) begin
      rnd    = $random(seed);
      op_sel = rnd % 32'd9;
      op     = isa_pkg::opcode_e'(op_sel[3:0]);
      rnd    = $random(seed);
      value  = $random(seed);
      run_command(op, rnd[4:0], rnd[9:5], rnd[14:10], value, rnd[19:16] == 4'd0);
    end

    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
